// ==== hdl/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Instruction stream is byte wide
`define DEC_BYTE_W   8

// Register code, high bit flags sreg in src or unused in base/index
`define DEC_REG_W    4

// Segment register code
`define DEC_SEG_W    2

`define DEC_REG_NONE 4'b1100  // No base or no index in the EA sum

`define DEC_SEG_DS   2'b11    // Default data segment
`define DEC_SEG_SS   2'b10    // Stack segment, used for BP based forms

`endif

// ==== hdl/decode_pkg.sv ====
`include "decode_config.svh"

package decode_pkg;

    typedef struct packed {
        logic [`DEC_BYTE_W-1:0] opcode;
        logic [`DEC_BYTE_W-1:0] modrm;
    } decode_req_t;

    // Effective address registers
    typedef struct packed {
        logic [`DEC_REG_W-1:0] base;
        logic [`DEC_REG_W-1:0] index;
        logic [`DEC_SEG_W-1:0] seg;
    } ea_t;

    typedef struct packed {
        logic [2:0] reg_field;
        logic [2:0] rm_field;
        logic       reg_mode;   // mod 11, register operand
        logic       disp_need;
        logic       disp_size;  // 0 -> 8 bit, 1 -> 16 bit
        ea_t        ea;
    } modrm_info_t;

    typedef struct packed {
        logic                  need_modrm;
        logic                  need_disp;
        logic                  disp_size;  // 0 -> 8 bit, 1 -> 16 bit
        logic                  need_imm;
        logic                  imm_size;   // 0 -> 8 bit, 1 -> 16 bit
        logic [`DEC_REG_W-1:0] src;
        logic [`DEC_REG_W-1:0] dst;
        ea_t                   ea;
    } decode_result_t;

    // Opcode groups with a common operand layout
    typedef enum logic [3:0] {
        cls_none,
        cls_alu_rm_r,
        cls_acc_imm,
        cls_rm_imm,
        cls_mov_sreg,
        cls_lea,
        cls_pop_rm,
        cls_xchg_acc,
        cls_mov_r_imm,
        cls_shift_imm,
        cls_ret_pop,
        cls_les_lds,
        cls_mov_m_acc,
        cls_jcc,
        cls_call_far
    } op_class_t;

endpackage

// ==== hdl/modrm_decoder.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module modrm_decoder
(
    input  logic [`DEC_BYTE_W-1:0] modrm,
    output decode_pkg::modrm_info_t info
);

    localparam logic [`DEC_REG_W-1:0] reg_bx = 4'b0011;
    localparam logic [`DEC_REG_W-1:0] reg_bp = 4'b0101;
    localparam logic [`DEC_REG_W-1:0] reg_si = 4'b0110;
    localparam logic [`DEC_REG_W-1:0] reg_di = 4'b0111;

    logic [1:0] mod_field;
    logic [2:0] rm;
    logic       direct;  // mod 00 rm 110, 16 bit address only

    assign mod_field = modrm[7:6];
    assign rm        = modrm[2:0];
    assign direct    = (mod_field == 2'b00) && (rm == 3'b110);

    always_comb
    begin
        info.reg_field = modrm[5:3];
        info.rm_field  = rm;
        info.reg_mode  = (mod_field == 2'b11);
        info.disp_need = direct | ^mod_field;  // mod 01 and 10 carry a displacement
        info.disp_size = direct | (mod_field == 2'b10);

        // EA register pair and default segment per rm
        case (rm)
            3'b000:
            begin
                info.ea.base  = reg_bx;
                info.ea.index = reg_si;
                info.ea.seg   = `DEC_SEG_DS;
            end
            3'b001:
            begin
                info.ea.base  = reg_bx;
                info.ea.index = reg_di;
                info.ea.seg   = `DEC_SEG_DS;
            end
            3'b010:
            begin
                info.ea.base  = reg_bp;
                info.ea.index = reg_si;
                info.ea.seg   = `DEC_SEG_SS;
            end
            3'b011:
            begin
                info.ea.base  = reg_bp;
                info.ea.index = reg_di;
                info.ea.seg   = `DEC_SEG_SS;
            end
            3'b100:
            begin
                info.ea.base  = `DEC_REG_NONE;
                info.ea.index = reg_si;
                info.ea.seg   = `DEC_SEG_DS;
            end
            3'b101:
            begin
                info.ea.base  = `DEC_REG_NONE;
                info.ea.index = reg_di;
                info.ea.seg   = `DEC_SEG_DS;
            end
            3'b110:
            begin
                info.ea.base  = direct ? `DEC_REG_NONE : reg_bp;  // Direct address has no base
                info.ea.index = `DEC_REG_NONE;
                info.ea.seg   = direct ? `DEC_SEG_DS : `DEC_SEG_SS;
            end
            default:
            begin
                info.ea.base  = reg_bx;  // rm 111
                info.ea.index = `DEC_REG_NONE;
                info.ea.seg   = `DEC_SEG_DS;
            end
        endcase
    end

endmodule

// ==== hdl/opcode_decoder.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module opcode_decoder
(
    input  logic [`DEC_BYTE_W-1:0]     opcode,
    input  decode_pkg::modrm_info_t    info,
    output decode_pkg::decode_result_t result
);

    decode_pkg::op_class_t op_class;
    logic [2:0]            dst_sel;  // Direction bit set means reg is the destination
    logic [2:0]            src_sel;
    logic                  modrm_form;

    assign dst_sel = opcode[1] ? info.reg_field : info.rm_field;
    assign src_sel = opcode[1] ? info.rm_field : info.reg_field;

    // Group lookup, first match wins
    always_comb
    begin
        casez (opcode)
            8'b00??_?0??: op_class = decode_pkg::cls_alu_rm_r;
            8'b00??_?10?: op_class = decode_pkg::cls_acc_imm;
            8'b0111_????: op_class = decode_pkg::cls_jcc;
            8'b1000_00??: op_class = decode_pkg::cls_rm_imm;
            8'b1000_01??: op_class = decode_pkg::cls_alu_rm_r;  // TEST and XCHG
            8'b1000_10??: op_class = decode_pkg::cls_alu_rm_r;  // MOV R/M,R
            8'b1000_11?0: op_class = decode_pkg::cls_mov_sreg;
            8'b1000_1101: op_class = decode_pkg::cls_lea;
            8'b1000_1111: op_class = decode_pkg::cls_pop_rm;
            8'b1001_0???: op_class = decode_pkg::cls_xchg_acc;
            8'b1001_1010: op_class = decode_pkg::cls_call_far;
            8'b1010_00??: op_class = decode_pkg::cls_mov_m_acc;
            8'b1011_????: op_class = decode_pkg::cls_mov_r_imm;
            8'b1100_000?: op_class = decode_pkg::cls_shift_imm;
            8'b1100_0010: op_class = decode_pkg::cls_ret_pop;
            8'b1100_010?: op_class = decode_pkg::cls_les_lds;
            default:      op_class = decode_pkg::cls_none;
        endcase
    end

    assign modrm_form = op_class inside {decode_pkg::cls_alu_rm_r, decode_pkg::cls_rm_imm,
                                         decode_pkg::cls_mov_sreg, decode_pkg::cls_lea,
                                         decode_pkg::cls_pop_rm, decode_pkg::cls_shift_imm,
                                         decode_pkg::cls_les_lds};

    always_comb
    begin
        result = '0;
        if (op_class != decode_pkg::cls_none)
            result.ea = info.ea;
        if (modrm_form)
        begin
            result.need_modrm = 1'b1;
            result.need_disp  = info.disp_need;
            result.disp_size  = info.disp_size;
        end

        case (op_class)
            decode_pkg::cls_alu_rm_r:
            begin
                result.dst = {1'b0, dst_sel};
                result.src = {1'b0, src_sel};
            end
            decode_pkg::cls_acc_imm:
            begin
                result.need_imm = 1'b1;
                result.imm_size = opcode[0];  // Width bit
            end
            decode_pkg::cls_rm_imm:
            begin
                result.need_imm = 1'b1;
                result.imm_size = !opcode[1] & opcode[0];  // Only 81 takes imm16
                result.dst      = {1'b0, info.rm_field};
            end
            decode_pkg::cls_mov_sreg:
            begin
                result.src = {1'b1, src_sel};  // Segment register flag
                if (info.reg_mode)
                    result.dst = {1'b0, dst_sel};
            end
            decode_pkg::cls_lea:       result.dst = {1'b0, dst_sel};
            decode_pkg::cls_pop_rm:    result.dst = {1'b0, info.rm_field};
            decode_pkg::cls_xchg_acc:  result.src = {1'b0, opcode[2:0]};
            decode_pkg::cls_mov_r_imm:
            begin
                result.need_imm = 1'b1;
                result.imm_size = opcode[3];  // Width bit sits at bit 3 here
                result.dst      = {1'b0, opcode[2:0]};
            end
            decode_pkg::cls_shift_imm:
            begin
                result.need_imm = 1'b1;  // Count is always imm8
                result.dst      = {1'b0, info.rm_field};
                result.src      = {1'b0, info.rm_field};
            end
            decode_pkg::cls_ret_pop:
            begin
                result.need_imm = 1'b1;
                result.imm_size = 1'b1;
            end
            decode_pkg::cls_les_lds:   result.src = {1'b0, info.reg_field};
            decode_pkg::cls_mov_m_acc:
            begin
                result.need_disp = 1'b1;  // 16 bit direct address
                result.disp_size = 1'b1;
            end
            decode_pkg::cls_jcc:       result.need_disp = 1'b1;
            decode_pkg::cls_call_far:
            begin
                // Offset in the disp slot, segment as imm16
                result.need_disp = 1'b1;
                result.disp_size = 1'b1;
                result.need_imm  = 1'b1;
                result.imm_size  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/decode_handshake.sv ====
`timescale 1ns/1ps

module decode_handshake
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    output logic                       ack,
    input  decode_pkg::decode_result_t result_in,
    output decode_pkg::decode_result_t result
);

    logic accept;  // New request seen while idle

    assign accept = req && !ack;

    // Ack state, four-phase slave side
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ack <= 1'b0;
        end
        else if (accept)
        begin
            ack <= 1'b1;
        end
        else if (!req)
        begin
            ack <= 1'b0;  // Requester released, return to idle
        end
    end

    // Result frozen from accept until the next accept
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            result <= '0;
        end
        else if (accept)
        begin
            result <= result_in;
        end
    end

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  decode_pkg::decode_req_t    request,
    output logic                       ack,
    output decode_pkg::decode_result_t result
);

    decode_pkg::modrm_info_t    info;
    decode_pkg::decode_result_t decoded;  // Combinational decode of the current request

    modrm_decoder u_modrm_decoder
    (
        .modrm  (request.modrm),
        .info   (info)
    );

    opcode_decoder u_opcode_decoder
    (
        .opcode (request.opcode),
        .info   (info),
        .result (decoded)
    );

    decode_handshake u_decode_handshake
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .result_in (decoded),
        .result    (result)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

endmodule

// ==== tests/decode_unit_properties.sv ====
`timescale 1ns/1ps

module decode_unit_properties
(
    input logic                       clk,
    input logic                       rst_n,
    input logic                       req,
    input logic                       ack,
    input decode_pkg::decode_result_t result
);

    ack_needs_req: assert property
    (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    )
    else $error("ack rose without a pending request");

    ack_held: assert property
    (
        @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack
    )
    else $error("ack dropped while req was still high");

    result_frozen: assert property
    (
        @(posedge clk) disable iff (!rst_n) ack |=> $stable(result)
    )
    else $error("result changed while ack was high");

    // Synchronous reset clears ack one edge later
    ack_low_in_reset: assert property
    (
        @(posedge clk) !rst_n |=> !ack
    )
    else $error("ack high during reset");

endmodule

bind decode_handshake decode_unit_properties u_properties
(
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .ack    (ack),
    .result (result)
);

// ==== tests/tb_decode_unit.sv ====
`timescale 1ns/1ps

module tb_decode_unit;

    logic                       clk;
    logic                       rst_n;
    logic                       req;
    decode_pkg::decode_req_t    request;
    logic                       ack;
    decode_pkg::decode_result_t result;

    decode_pkg::decode_req_t    vec_req [$];
    decode_pkg::decode_result_t vec_exp [$];
    decode_pkg::decode_req_t    rq;
    decode_pkg::decode_result_t ex;
    int    mismatch_count = 0;
    int    other_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    fd;
    int    fields;
    int    c [12];
    int    idle;
    int    hold;
    int    edges;
    string line;

    tb_clock_gen u_clock_gen
    (
        .clk (clk)
    );

    decode_unit dut
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got)
        begin
            $display("MISMATCH %s exp=%0h got=%0h", name, exp, got);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    task automatic compare_result(input decode_pkg::decode_result_t exp);
        check_value("need_modrm", 32'(exp.need_modrm), 32'(result.need_modrm));
        check_value("need_disp", 32'(exp.need_disp), 32'(result.need_disp));
        check_value("disp_size", 32'(exp.disp_size), 32'(result.disp_size));
        check_value("need_imm", 32'(exp.need_imm), 32'(result.need_imm));
        check_value("imm_size", 32'(exp.imm_size), 32'(result.imm_size));
        check_value("src", 32'(exp.src), 32'(result.src));
        check_value("dst", 32'(exp.dst), 32'(result.dst));
        check_value("ea.base", 32'(exp.ea.base), 32'(result.ea.base));
        check_value("ea.index", 32'(exp.ea.index), 32'(result.ea.index));
        check_value("ea.seg", 32'(exp.ea.seg), 32'(result.ea.seg));
    endtask

    // Run length limit over all vectors
    initial
    begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout waiting for ack");
        other_count++;
        finish_run();
    end

    initial
    begin
        rst_n   = 1'b0;
        req     = 1'b0;
        request = '0;
        void'($urandom(32'h1d6d_ee8a));

        fd = $fopen("tests/decode_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tests/decode_input.txt");
            other_count++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")  // Skip comments and blanks
                begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                     c[0], c[1], c[2], c[3], c[4], c[5],
                                     c[6], c[7], c[8], c[9], c[10], c[11]);
                    if (fields != 12)
                    begin
                        $display("Malformed stimulus line skipped: %s", line);
                        other_count++;
                    end
                    else
                    begin
                        rq.opcode     = c[0][7:0];
                        rq.modrm      = c[1][7:0];
                        ex.need_modrm = c[2][0];
                        ex.need_disp  = c[3][0];
                        ex.disp_size  = c[4][0];
                        ex.need_imm   = c[5][0];
                        ex.imm_size   = c[6][0];
                        ex.src        = c[7][3:0];
                        ex.dst        = c[8][3:0];
                        ex.ea.base    = c[9][3:0];
                        ex.ea.index   = c[10][3:0];
                        ex.ea.seg     = c[11][1:0];
                        vec_req.push_back(rq);
                        vec_exp.push_back(ex);
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_req.size() == 0)
        begin
            $display("No stimulus vectors were read");
            other_count++;
        end
        cycle_limit = vec_req.size() * 10 + 50;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("ack", 32'd0, 32'(ack));  // Still cleared from reset
        check_value("result", 32'd0, 32'(result));

        for (int i = 0; i < vec_req.size(); i++)
        begin
            idle = int'($urandom % 4);
            hold = int'($urandom % 3);
            repeat (idle) @(posedge clk);
            @(posedge clk);
            req     <= 1'b1;
            request <= vec_req[i];
            edges = 0;
            @(negedge clk);
            while (!ack)
            begin
                @(posedge clk);
                edges++;
                @(negedge clk);
            end
            check_value("ack_latency", 32'd1, 32'(edges));
            compare_result(vec_exp[i]);

            repeat (hold)
            begin
                @(posedge clk);
                request <= ~vec_req[i];  // Illegal change must not reach result
                @(negedge clk);
                check_value("ack", 32'd1, 32'(ack));
                check_value("result", 32'(vec_exp[i]), 32'(result));
            end

            @(posedge clk);
            req <= 1'b0;
            @(posedge clk);
            @(negedge clk);
            check_value("ack", 32'd0, 32'(ack));
        end

        finish_run();
    end

endmodule

// ==== tests/decode_input.txt ====
# opcode modrm need_modrm need_disp disp_size need_imm imm_size src dst base index seg
# all hex, base/index c means none, seg 3 is DS and 2 is SS
00 11 1 0 0 0 0 2 1 3 7 3
02 11 1 0 0 0 0 1 2 3 7 3
01 5a 1 1 0 0 0 3 2 5 6 2
2b a3 1 1 1 0 0 3 4 5 7 2
30 cf 1 0 0 0 0 1 7 3 c 3
10 2e 1 1 1 0 0 5 6 c c 3
21 bc 1 1 1 0 0 7 4 c 6 3
09 1d 1 0 0 0 0 3 5 c 7 3
04 00 0 0 0 1 0 0 0 3 6 3
3d 00 0 0 0 1 1 0 0 3 6 3
80 c3 1 0 0 1 0 0 3 5 7 2
81 a8 1 1 1 1 1 0 0 3 6 3
83 3e 1 1 1 1 0 0 6 c c 3
b8 00 0 0 0 1 1 0 0 3 6 3
c1 ee 1 0 0 1 0 6 6 5 c 2
c2 00 0 0 0 1 1 0 0 3 6 3
74 00 0 1 0 0 0 0 0 3 6 3
a1 00 0 1 1 0 0 0 0 3 6 3
9a 00 0 1 1 1 1 0 0 3 6 3
8c d9 1 0 0 0 0 b 1 3 7 3
8f 04 1 0 0 0 0 0 4 c 6 3
93 00 0 0 0 0 0 3 0 3 6 3
c4 6d 1 1 0 0 0 5 0 c 7 3
40 5a 0 0 0 0 0 0 0 0 0 0
50 ff 0 0 0 0 0 0 0 0 0 0
a4 12 0 0 0 0 0 0 0 0 0 0
26 46 0 0 0 0 0 0 0 0 0 0
c8 2e 0 0 0 0 0 0 0 0 0 0
fc 00 0 0 0 0 0 0 0 0 0 0

// ==== filelist.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/modrm_decoder.sv
hdl/opcode_decoder.sv
hdl/decode_handshake.sv
hdl/decode_unit.sv
tests/tb_clock_gen.sv
tests/decode_unit_properties.sv
tests/tb_decode_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_decode_unit \
    -f filelist.f -o tb_decode_unit > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_decode_unit > sim.log 2>&1 || echo "Simulator exited with an error"
grep -q "Simulation PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
